// ==== filelist.f ====
+incdir+test
rtl/board_pkg.sv
rtl/board_input_if.sv
rtl/board_input_sync.sv
rtl/board_ctrl.sv
rtl/board_reset_gen.sv
rtl/board_game_map.sv
rtl/board_top.sv
test/tb_board_top.sv

// ==== rtl/board_ctrl.sv ====
// Board state control
// Pause toggle, graphics layer enables and soft reset request
`timescale 1ns/1ps
`default_nettype none

module board_ctrl (
    input  logic             clk_sys,
    input  logic             game_rst,
    board_input_if.ctrl      bus,
    output logic             game_pause,
    output board_pkg::gfx_t  gfx_en,
    output logic             soft_rst
);
    import board_pkg::*;

    // Pause starts off, every layer starts visible
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            game_pause <= 1'b0;
            gfx_en     <= '1;
            soft_rst   <= 1'b0;
        end else begin
            game_pause <= game_pause ^ bus.pause_rise;
            gfx_en     <= gfx_en ^ bus.gfx_rise;   // Each key flips its own layer
            soft_rst   <= bus.reset_rise;          // Single cycle, rise is one cycle
        end
    end

    // Layers come back after any reset, even if a key toggles right away
    a_gfx_after_rst : assert property (
        @(posedge clk_sys) game_rst |=> (gfx_en == gfx_t'('1))
    );

endmodule

`default_nettype wire

// ==== rtl/board_game_map.sv ====
// Game port mapping
// Merges board and keyboard sticks, rotates directions for vertical
// screens, extracts coin and start, applies the input polarity
`timescale 1ns/1ps
`default_nettype none

module board_game_map #(
    parameter int THREE_BUTTONS     = 0,
    parameter int INPUTS_ACTIVE_LOW = 1
) (
    input  logic              clk_sys,
    input  logic              game_rst,
    board_input_if.map        bus,
    input  logic              rot_control,
    output board_pkg::joy_t   game_joystick1,
    output board_pkg::joy_t   game_joystick2,
    output board_pkg::pair_t  game_coin,
    output board_pkg::pair_t  game_start,
    output logic              game_service
);
    import board_pkg::*;

    localparam int    COIN_BIT  = btn_pos(COIN_BASE, THREE_BUTTONS);
    localparam int    START_BIT = btn_pos(START_BASE, THREE_BUTTONS);
    localparam logic  INV       = INPUTS_ACTIVE_LOW != 0;
    localparam joy_t  JOY_INV   = {JOY_W{INV}};
    localparam pair_t PAIR_INV  = {$bits(pair_t){INV}};

    joy_t  joy1_all;
    joy_t  joy2_all;
    pair_t coin_all;
    pair_t start_all;

    // Quarter turn of the direction bits, buttons untouched
    function automatic joy_t rotate_dirs(input joy_t joy, input logic rot);
        if (rot) begin
            return {joy[JOY_W-1:4], joy[0], joy[1], joy[3], joy[2]};
        end
        return joy;
    endfunction

    assign joy1_all  = bus.joy1 | bus.key_joy1;
    assign joy2_all  = bus.joy2 | bus.key_joy2;
    assign coin_all  = {bus.joy2[COIN_BIT], bus.joy1[COIN_BIT]} | bus.key_coin;
    assign start_all = {bus.joy2[START_BIT], bus.joy1[START_BIT]} | bus.key_start;

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin     // Inactive level on all game inputs
            game_joystick1 <= JOY_INV;
            game_joystick2 <= JOY_INV;
            game_coin      <= PAIR_INV;
            game_start     <= PAIR_INV;
            game_service   <= INV;
        end else begin
            game_joystick1 <= JOY_INV ^ rotate_dirs(joy1_all, rot_control);
            game_joystick2 <= JOY_INV ^ rotate_dirs(joy2_all, rot_control);
            game_coin      <= PAIR_INV ^ coin_all;
            game_start     <= PAIR_INV ^ start_all;
            game_service   <= INV ^ bus.key_service;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/board_input_if.sv ====
// Synchronized player inputs and rise pulses
// Driven by the input register stage, read by control and game mapping
`timescale 1ns/1ps
`default_nettype none

interface board_input_if;
    import board_pkg::*;

    joy_t  joy1;          // Board sticks, registered
    joy_t  joy2;
    joy_t  key_joy1;      // Keyboard sticks, registered
    joy_t  key_joy2;
    pair_t key_coin;
    pair_t key_start;
    logic  key_service;
    logic  pause_rise;    // One-cycle pulses
    logic  reset_rise;
    gfx_t  gfx_rise;

    modport sync (
        output joy1, joy2, key_joy1, key_joy2,
        output key_coin, key_start, key_service,
        output pause_rise, reset_rise, gfx_rise
    );

    modport ctrl (
        input pause_rise, reset_rise, gfx_rise
    );

    modport map (
        input joy1, joy2, key_joy1, key_joy2,
        input key_coin, key_start, key_service
    );

endinterface

`default_nettype wire

// ==== rtl/board_input_sync.sv ====
// Input register stage
// Samples joysticks and decoded keys into clk_sys, forms rise pulses
`timescale 1ns/1ps
`default_nettype none

module board_input_sync #(
    parameter int THREE_BUTTONS = 0
) (
    input  logic              clk_sys,
    input  logic              game_rst,
    input  board_pkg::joy_t   board_joystick1,
    input  board_pkg::joy_t   board_joystick2,
    input  board_pkg::joy_t   key_joy1,
    input  board_pkg::joy_t   key_joy2,
    input  board_pkg::pair_t  key_coin,
    input  board_pkg::pair_t  key_start,
    input  logic              key_service,
    input  logic              key_pause,
    input  logic              key_reset,
    input  board_pkg::gfx_t   key_gfx,
    board_input_if.sync       bus
);
    import board_pkg::*;

    localparam int PAUSE_BIT = btn_pos(PAUSE_BASE, THREE_BUTTONS);

    logic       pause_key_q;
    logic       reset_key_q;
    gfx_t       gfx_key_q;
    logic [2:0] pause_src;      // Stick 2, stick 1, key
    logic [2:0] pause_hist;
    logic       reset_hist;
    gfx_t       gfx_hist;

    always_ff @(posedge clk_sys) begin
        bus.joy1        <= board_joystick1;
        bus.joy2        <= board_joystick2;
        bus.key_joy1    <= key_joy1;
        bus.key_joy2    <= key_joy2;
        bus.key_coin    <= key_coin;
        bus.key_start   <= key_start;
        bus.key_service <= key_service;
        pause_key_q     <= key_pause;
        reset_key_q     <= key_reset;
        gfx_key_q       <= key_gfx;
    end

    assign pause_src = {bus.joy2[PAUSE_BIT], bus.joy1[PAUSE_BIT], pause_key_q};

    // History preset to ones so a level held through reset gives no edge
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            pause_hist <= '1;
            reset_hist <= 1'b1;
            gfx_hist   <= '1;
        end else begin
            pause_hist <= pause_src;
            reset_hist <= reset_key_q;
            gfx_hist   <= gfx_key_q;
        end
    end

    assign bus.pause_rise = |(pause_src & ~pause_hist);  // Any of the three
    assign bus.reset_rise = reset_key_q & ~reset_hist;
    assign bus.gfx_rise   = gfx_key_q & ~gfx_hist;

    a_reset_rise_single : assert property (
        @(posedge clk_sys) bus.reset_rise |=> !bus.reset_rise
    );

endmodule

`default_nettype wire

// ==== rtl/board_pkg.sv ====
// Shared types for the board input and reset logic
// Joystick, player pair and graphics group widths, button positions
// and the reset generator state
`default_nettype none

package board_pkg;

    localparam int JOY_W = 10;  // 4 directions plus buttons
    localparam int GFX_W = 4;   // Graphics layers

    // Direction bits in 3..0, buttons above
    typedef logic [JOY_W-1:0] joy_t;

    // Bit 0 is player 1
    typedef logic [1:0] pair_t;

    typedef logic [GFX_W-1:0] gfx_t;

    // Button positions with two buttons per stick
    localparam int COIN_BASE  = 6;
    localparam int START_BASE = 7;
    localparam int PAUSE_BASE = 8;

    // A third fire button pushes coin, start and pause up by one
    function automatic int btn_pos(input int base, input int three_buttons);
        return base + three_buttons;
    endfunction

    typedef enum logic {
        RST_IDLE,
        RST_HOLD
    } rst_state_t;

endpackage

`default_nettype wire

// ==== rtl/board_reset_gen.sv ====
// Game reset generator
// Stretches board reset, soft reset, reset requests and
// flip changes into core_rst with a hold counter
`timescale 1ns/1ps
`default_nettype none

module board_reset_gen #(
    parameter int RST_CYCLES = 16
) (
    input  logic clk_sys,
    input  logic game_rst,
    input  logic rst_req,
    input  logic dip_flip,
    input  logic soft_rst,
    output logic core_rst
);
    import board_pkg::*;

    localparam int CNT_W = $clog2(RST_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RST_CYCLES - 1);

    rst_state_t       state;
    logic [CNT_W-1:0] hold_cnt;
    logic             last_flip;
    logic             flip_chg;
    logic             cause;

    assign flip_chg = dip_flip != last_flip;   // Either direction
    assign cause    = rst_req | soft_rst | flip_chg;

    always_ff @(posedge clk_sys) begin
        last_flip <= dip_flip;
        if (game_rst) begin
            state    <= RST_HOLD;
            hold_cnt <= '0;
        end else if (cause) begin
            state    <= RST_HOLD;   // Restart the stretch
            hold_cnt <= '0;
        end else begin
            case (state)
                RST_HOLD: begin
                    if (hold_cnt == CNT_LAST) begin
                        state <= RST_IDLE;
                    end
                    hold_cnt <= hold_cnt + 1'b1;
                end
                default: begin
                    hold_cnt <= '0;
                end
            endcase
        end
    end

    // Board reset reaches the core without waiting for an edge
    assign core_rst = game_rst | (state == RST_HOLD);

    // Core stays in reset past the end of the board reset
    a_core_rst_hold : assert property (
        @(posedge clk_sys) game_rst |-> core_rst ##1 core_rst
    );

endmodule

`default_nettype wire

// ==== rtl/board_top.sv ====
// Board input and reset control top level
// Input registers, board state, game port mapping and reset stretching
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int THREE_BUTTONS     = 0,
    parameter int INPUTS_ACTIVE_LOW = 1,
    parameter int RST_CYCLES        = 16
) (
    input  logic                         clk_sys,
    input  logic                         game_rst,
    input  logic                         rst_req,
    input  logic                         dip_flip,
    input  logic                         rot_control,
    input  logic [board_pkg::JOY_W-1:0]  board_joystick1,
    input  logic [board_pkg::JOY_W-1:0]  board_joystick2,
    input  logic [board_pkg::JOY_W-1:0]  key_joy1,
    input  logic [board_pkg::JOY_W-1:0]  key_joy2,
    input  logic [1:0]                   key_coin,
    input  logic [1:0]                   key_start,
    input  logic                         key_service,
    input  logic                         key_pause,
    input  logic                         key_reset,
    input  logic [board_pkg::GFX_W-1:0]  key_gfx,
    output logic                         core_rst,
    output logic                         game_pause,
    output logic                         game_service,
    output logic [board_pkg::JOY_W-1:0]  game_joystick1,
    output logic [board_pkg::JOY_W-1:0]  game_joystick2,
    output logic [1:0]                   game_coin,
    output logic [1:0]                   game_start,
    output logic [board_pkg::GFX_W-1:0]  gfx_en
);

    logic soft_rst;     // Reset key rise, one cycle

    board_input_if bus_if ();

    board_input_sync #(
        .THREE_BUTTONS (THREE_BUTTONS)
    ) board_input_sync_inst (
        .clk_sys         (clk_sys),
        .game_rst        (game_rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .key_joy1        (key_joy1),
        .key_joy2        (key_joy2),
        .key_coin        (key_coin),
        .key_start       (key_start),
        .key_service     (key_service),
        .key_pause       (key_pause),
        .key_reset       (key_reset),
        .key_gfx         (key_gfx),
        .bus             (bus_if.sync)
    );

    board_ctrl board_ctrl_inst (
        .clk_sys    (clk_sys),
        .game_rst   (game_rst),
        .bus        (bus_if.ctrl),
        .game_pause (game_pause),
        .gfx_en     (gfx_en),
        .soft_rst   (soft_rst)
    );

    board_game_map #(
        .THREE_BUTTONS     (THREE_BUTTONS),
        .INPUTS_ACTIVE_LOW (INPUTS_ACTIVE_LOW)
    ) board_game_map_inst (
        .clk_sys        (clk_sys),
        .game_rst       (game_rst),
        .bus            (bus_if.map),
        .rot_control    (rot_control),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service)
    );

    board_reset_gen #(
        .RST_CYCLES (RST_CYCLES)
    ) board_reset_gen_inst (
        .clk_sys  (clk_sys),
        .game_rst (game_rst),
        .rst_req  (rst_req),
        .dip_flip (dip_flip),
        .soft_rst (soft_rst),
        .core_rst (core_rst)
    );

endmodule

`default_nettype wire

// ==== test/tb_board_cases.svh ====
// Directed stimulus rows for the board testbench
// Inputs per row with hand computed active-low game outputs

// Row layout is rst_req, dip_flip, rot_control, board sticks 1 and 2, key sticks 1 and 2,
// then coin, start, service, pause, reset and gfx keys, then expected sticks, coin, start, service
task automatic load_cases();
    // Idle, single direction, OR of board and keys
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h000, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h3ff, 10'h3ff, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h001, 10'h000, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h3fe, 10'h3ff, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h001, 10'h000, 10'h002, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h3fc, 10'h3ff, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h030, 10'h000, 10'h200,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h3ff, 10'h1cf, 2'b11, 2'b11, 1'b1);
    // Coin from stick 1 bit 6 plus key, start from stick 2 bit 7
    add_case(1'b0, 1'b0, 1'b0, 10'h040, 10'h000, 10'h000, 10'h000,
             2'b10, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h3bf, 10'h3ff, 2'b00, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h080, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h3ff, 10'h37f, 2'b11, 2'b01, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h000, 10'h000, 10'h000,
             2'b00, 2'b01, 1'b1, 1'b0, 1'b0, 4'h0, 10'h3ff, 10'h3ff, 2'b11, 2'b10, 1'b0);
    // Vertical screen rotation
    add_case(1'b0, 1'b0, 1'b1, 10'h001, 10'h008, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h3f7, 10'h3fd, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b1, 10'h000, 10'h000, 10'h002, 10'h004,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h3fb, 10'h3fe, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b1, 10'h3f1, 10'h000, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h0, 10'h007, 10'h3ff, 2'b10, 2'b10, 1'b1);
    // Pause key rise, held key, then stick 2 pause bit
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h000, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b1, 1'b0, 4'h0, 10'h3ff, 10'h3ff, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h000, 10'h100, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b1, 1'b0, 4'h0, 10'h2ff, 10'h3ff, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h100, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b1, 1'b0, 4'h0, 10'h3ff, 10'h2ff, 2'b11, 2'b11, 1'b1);
    // Graphics layer keys
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h100, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h1, 10'h3ff, 10'h2ff, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h000, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'h5, 10'h3ff, 10'h3ff, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b0, 10'h000, 10'h000, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'ha, 10'h3ff, 10'h3ff, 2'b11, 2'b11, 1'b1);
    add_case(1'b0, 1'b0, 1'b1, 10'h00f, 10'h000, 10'h000, 10'h000,
             2'b00, 2'b00, 1'b0, 1'b0, 1'b0, 4'ha, 10'h3f0, 10'h3ff, 2'b11, 2'b11, 1'b1);
endtask

// ==== test/tb_board_top.sv ====
// Testbench for the board input and reset control top level
// Table driven mapping checks, pause and graphics model, reset causes
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;
    import board_pkg::*;

    localparam int RST_CYCLES = 16;
    localparam int COIN_BIT   = 6;
    localparam int START_BIT  = 7;
    localparam int PAUSE_BIT  = 8;
    localparam int RAND_ROWS  = 16;

    typedef struct packed {
        logic  rst_req;
        logic  dip_flip;
        logic  rot_control;
        joy_t  board_joy1;
        joy_t  board_joy2;
        joy_t  key_joy1;
        joy_t  key_joy2;
        pair_t key_coin;
        pair_t key_start;
        logic  key_service;
        logic  key_pause;
        logic  key_reset;
        gfx_t  key_gfx;
        joy_t  exp_joy1;
        joy_t  exp_joy2;
        pair_t exp_coin;
        pair_t exp_start;
        logic  exp_service;
    } case_t;

    logic  clk_sys;
    logic  game_rst;
    logic  rst_req;
    logic  dip_flip;
    logic  rot_control;
    joy_t  board_joystick1;
    joy_t  board_joystick2;
    joy_t  key_joy1;
    joy_t  key_joy2;
    pair_t key_coin;
    pair_t key_start;
    logic  key_service;
    logic  key_pause;
    logic  key_reset;
    gfx_t  key_gfx;
    logic  core_rst;
    logic  game_pause;
    logic  game_service;
    joy_t  game_joystick1;
    joy_t  game_joystick2;
    pair_t game_coin;
    pair_t game_start;
    gfx_t  gfx_en;

    case_t      cases[$];
    integer     seed = 32'h782c310f;
    int         error_count = 0;
    logic       model_pause;
    gfx_t       model_gfx;
    logic [2:0] prev_pause_src;     // Stick 2, stick 1, key
    gfx_t       prev_gfx;

    board_top board_top_inst (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    task automatic add_case(
        input logic rq, input logic fl, input logic rot,
        input joy_t bj1, input joy_t bj2, input joy_t kj1, input joy_t kj2,
        input pair_t kc, input pair_t ks, input logic sv, input logic pa,
        input logic rs, input gfx_t kg,
        input joy_t ej1, input joy_t ej2, input pair_t ec, input pair_t es, input logic esv
    );
        case_t row;
        row = {rq, fl, rot, bj1, bj2, kj1, kj2, kc, ks, sv, pa, rs, kg, ej1, ej2, ec, es, esv};
        cases.push_back(row);
    endtask

    `include "tb_board_cases.svh"

    // Reference stick mapping, OR then quarter turn then active low
    function automatic joy_t expect_joy(input joy_t stick, input joy_t keys, input logic rot);
        joy_t merged;
        joy_t turned;
        merged = stick | keys;
        turned = merged;
        if (rot) begin
            turned[3] = merged[0];
            turned[2] = merged[1];
            turned[1] = merged[3];
            turned[0] = merged[2];
        end
        return ~turned;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_core_rst(input logic level, input int max_cycles, input string what);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            @(posedge clk_sys);
            #1;
            seen = (core_rst === level);
        end
        assert (seen) else begin
            error_count++;
            $display("core_rst did not go to %0b within %0d cycles after %s",
                     level, max_cycles, what);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive_row(input case_t row);
        rst_req         = row.rst_req;
        dip_flip        = row.dip_flip;
        rot_control     = row.rot_control;
        board_joystick1 = row.board_joy1;
        board_joystick2 = row.board_joy2;
        key_joy1        = row.key_joy1;
        key_joy2        = row.key_joy2;
        key_coin        = row.key_coin;
        key_start       = row.key_start;
        key_service     = row.key_service;
        key_pause       = row.key_pause;
        key_reset       = row.key_reset;
        key_gfx         = row.key_gfx;
    endtask

    task automatic run_row(input case_t row);
        logic [2:0] pause_src;
        pause_src = {row.board_joy2[PAUSE_BIT], row.board_joy1[PAUSE_BIT], row.key_pause};
        drive_row(row);
        // Rises seen between this row and the last one
        if (|(pause_src & ~prev_pause_src)) begin
            model_pause = ~model_pause;
        end
        model_gfx      = model_gfx ^ (row.key_gfx & ~prev_gfx);
        prev_pause_src = pause_src;
        prev_gfx       = row.key_gfx;
        repeat (3) @(posedge clk_sys);
        #1;
        check_value("game_joystick1", row.exp_joy1, game_joystick1);
        check_value("game_joystick2", row.exp_joy2, game_joystick2);
        check_value("game_coin", row.exp_coin, game_coin);
        check_value("game_start", row.exp_start, game_start);
        check_value("game_service", row.exp_service, game_service);
        check_value("game_pause", model_pause, game_pause);
        check_value("gfx_en", model_gfx, gfx_en);
    endtask

    task automatic apply_reset_cause(input int cause, input string what);
        check_value("core_rst", 1'b0, core_rst);
        case (cause)
            0: rst_req = 1'b1;
            1: key_reset = 1'b1;
            default: dip_flip = ~dip_flip;
        endcase
        wait_core_rst(1'b1, 4, what);
        rst_req   = 1'b0;   // Pulse ends at the first edge it is seen
        key_reset = 1'b0;
        wait_core_rst(1'b0, RST_CYCLES + 4, what);
    endtask

    initial begin
        int    limit_ns;
        #1;
        limit_ns = (cases.size() + RAND_ROWS) * (RST_CYCLES + 10) * 10 * 2;
        #(limit_ns);
        $display("Timeout, the test did not finish within %0d ns", limit_ns);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        case_t       row;
        logic [31:0] rnd;
        row = '0;
        game_rst = 1'b1;
        drive_row(row);
        load_cases();
        model_pause    = 1'b0;
        model_gfx      = '1;
        prev_pause_src = '0;
        prev_gfx       = '0;
        repeat (3) @(posedge clk_sys);
        #1;
        game_rst = 1'b0;

        wait_core_rst(1'b0, RST_CYCLES + 4, "board reset");
        check_value("game_pause", 1'b0, game_pause);
        check_value("gfx_en", 4'hf, gfx_en);
        check_value("game_joystick1", 10'h3ff, game_joystick1);
        check_value("game_joystick2", 10'h3ff, game_joystick2);
        check_value("game_coin", 2'b11, game_coin);
        check_value("game_start", 2'b11, game_start);
        check_value("game_service", 1'b1, game_service);

        foreach (cases[i]) begin
            run_row(cases[i]);
        end

        for (int n = 0; n < RAND_ROWS; n++) begin
            row = '0;
            rnd = $random(seed);
            row.board_joy1  = rnd[9:0];
            row.board_joy2  = rnd[19:10];
            row.rot_control = rnd[20];
            rnd = $random(seed);
            row.key_joy1    = rnd[9:0];
            row.key_joy2    = rnd[19:10];
            row.exp_joy1    = expect_joy(row.board_joy1, row.key_joy1, row.rot_control);
            row.exp_joy2    = expect_joy(row.board_joy2, row.key_joy2, row.rot_control);
            row.exp_coin    = ~{row.board_joy2[COIN_BIT], row.board_joy1[COIN_BIT]};
            row.exp_start   = ~{row.board_joy2[START_BIT], row.board_joy1[START_BIT]};
            row.exp_service = 1'b1;
            run_row(row);
        end

        apply_reset_cause(0, "rst_req pulse");
        apply_reset_cause(1, "key_reset rise");
        apply_reset_cause(2, "dip_flip rise");
        apply_reset_cause(2, "dip_flip fall");

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
